// ==== turf_hsk_top.f ====
+incdir+verification
src/turf_id_pkg.sv
src/turf_io_pkg.sv
src/turf_baud_tick.sv
src/turf_gpo_mux.sv
src/turf_emio_gpio.sv
src/turf_id_regs.sv
src/turf_hsk_top.sv
verification/tb_turf_hsk.sv

// ==== Bender.yml ====
package:
  name: turf_hsk

sources:
  - files:
      - src/turf_id_pkg.sv
      - src/turf_io_pkg.sv
      - src/turf_baud_tick.sv
      - src/turf_gpo_mux.sv
      - src/turf_emio_gpio.sv
      - src/turf_id_regs.sv
      - src/turf_hsk_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_turf_hsk.sv

// ==== verification/tb_turf_hsk_checks.svh ====
`ifndef TB_TURF_HSK_CHECKS_SVH
`define TB_TURF_HSK_CHECKS_SVH

// Error counts, one per kind of result
int data_errs  = 0;
int bit_errs   = 0;
int ctrl_errs  = 0;
int emio_errs  = 0;
int count_errs = 0;
int other_errs = 0;

task automatic reg_compare(string name, turf_id_pkg::reg_data_t exp,
                           turf_id_pkg::reg_data_t act);
    if (act !== exp) begin
        data_errs++;
        $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic bit_compare(string name, logic exp, logic act);
    if (act !== exp) begin
        bit_errs++;
        $display("MISMATCH %s: expected %b, actual %b at %0t", name, exp, act, $time);
    end
endtask

task automatic sel_compare(string name, turf_io_pkg::gpo_sel_t exp,
                           turf_io_pkg::gpo_sel_t act);
    if (act !== exp) begin
        ctrl_errs++;
        $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic btype_compare(string name, logic [7:0] exp, logic [7:0] act);
    if (act !== exp) begin
        ctrl_errs++;
        $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic emio_compare(string name, turf_io_pkg::emio_word_t exp,
                            turf_io_pkg::emio_word_t act);
    if (act !== exp) begin
        emio_errs++;
        $display("MISMATCH %s: expected %h, actual %h at %0t", name, exp, act, $time);
    end
endtask

task automatic count_compare(string name, int exp, int act);
    if (act != exp) begin
        count_errs++;
        $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

`endif

// ==== verification/tb_turf_hsk.sv ====
`timescale 1ns/100ps
module tb_turf_hsk;

    localparam int RESET_CYCLES = 3;
    localparam int TICK_CYCLES  = 2048;
    // Tick window plus under 700 cycles of directed tests, with margin
    localparam int CYCLE_LIMIT  = 3000;

    logic                              ps_clk;
    logic                              rst_n_i;
    logic                              wr_stb_i;
    logic                              rd_stb_i;
    turf_id_pkg::reg_addr_t            addr_i;
    turf_id_pkg::reg_data_t            wdata_i;
    turf_id_pkg::reg_data_t            rdata_o;
    logic [turf_id_pkg::NUM_LINKS-1:0] aurora_up_i;
    logic [turf_id_pkg::NUM_LINKS-1:0] bridge_timeout_i;
    logic                              gpo_en_o;
    turf_io_pkg::gpo_sel_t             gpo_select_o;
    logic [7:0]                        bridge_type_o;
    logic                              sync_ce_i;
    logic                              sync_d_i;
    logic                              run_ce_i;
    logic                              run_d_i;
    logic                              trig_ce_i;
    logic                              trig_d_i;
    logic                              pps_ce_i;
    logic                              pps_d_i;
    logic                              gpo_o;
    logic [1:0]                        timepulse_i;
    logic                              pps_pulse_i;
    logic                              hsk_complete_i;
    logic                              hsk_irq_i;
    logic                              uart_irq_b_i;
    logic                              photoshutter_i;
    logic [15:0]                       emio_o_i;
    logic [15:0]                       emio_t_i;
    turf_io_pkg::emio_word_t           emio_word_o;
    logic [1:0]                        gps_extint_o;
    logic                              hsk_16x_o;
    logic                              gps_16x_o;

    integer seed = 32'h3f2ebc3d;

    // Shadow of the writable register state
    logic       sh_en;
    logic [2:0] sh_sel;
    logic [7:0] sh_btype;
    logic [3:0] sh_sticky;
    logic       exp_gpo;
    logic       ticks_done;
    int         cycle_count;

    `include "tb_turf_hsk_checks.svh"

    turf_hsk_top dut (.*);

    initial begin
        ps_clk = 1'b0;
        forever #10 ps_clk = ~ps_clk;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic turf_id_pkg::reg_data_t expect_rdata(turf_id_pkg::reg_addr_t addr,
                                                           logic [3:0] up);
        turf_id_pkg::reg_data_t d;
        d = '0;
        case (addr)
            // ASCII "TURF"
            2'd0: d = 32'h54555246;
            2'd1: d = {turf_id_pkg::REV_B, turf_id_pkg::FW_DATE[14:0], turf_id_pkg::VER_MAJOR,
                       turf_id_pkg::VER_MINOR, turf_id_pkg::VER_REV};
            2'd2: d = {16'h0, sh_btype, 4'h0, sh_sel, sh_en};
            default: begin
                for (int n = 0; n < 4; n++) begin
                    d[4*n +: 4] = {2'b00, up[n], 1'b1};
                end
                d[19:16] = sh_sticky;
            end
        endcase
        return d;
    endfunction

    // Sources indexed by select code: sync, run, trig, pps
    function automatic logic next_gpo(logic prev, logic en, logic [2:0] sel,
                                      logic [3:0] ce, logic [3:0] d);
        if (!en || sel > 3'd3) begin
            return 1'b0;
        end
        return ce[sel[1:0]] ? d[sel[1:0]] : prev;
    endfunction

    function automatic turf_io_pkg::emio_word_t expect_emio(logic [1:0] tp, logic pps,
                                                           logic done, logic irq, logic uart_b);
        return {tp[1], pps, 7'b0, done, irq, uart_b};
    endfunction

    function automatic int expect_ticks(int cycles, int inc, int acc_w);
        longint prod;
        prod = longint'(cycles) * inc;
        return int'(prod >> acc_w);
    endfunction

    //////////////////////////////
    // Bus and source drivers
    //////////////////////////////

    task automatic next_cycle();
        @(posedge ps_clk);
        #2;
    endtask

    task automatic write_reg(turf_id_pkg::reg_addr_t addr, turf_id_pkg::reg_data_t data);
        wr_stb_i = 1'b1;
        addr_i   = addr;
        wdata_i  = data;
        next_cycle();
        wr_stb_i = 1'b0;
    endtask

    task automatic read_check(string name, turf_id_pkg::reg_addr_t addr);
        turf_id_pkg::reg_data_t exp;
        exp      = expect_rdata(addr, aurora_up_i);
        rd_stb_i = 1'b1;
        addr_i   = addr;
        next_cycle();
        rd_stb_i = 1'b0;
        reg_compare(name, exp, rdata_o);
    endtask

    task automatic drive_sources(logic [3:0] ce, logic [3:0] d);
        sync_ce_i = ce[0];
        sync_d_i  = d[0];
        run_ce_i  = ce[1];
        run_d_i   = d[1];
        trig_ce_i = ce[2];
        trig_d_i  = d[2];
        pps_ce_i  = ce[3];
        pps_d_i   = d[3];
    endtask

    task automatic gpo_cycle();
        logic [3:0] ce;
        logic [3:0] d;
        ce = $random(seed);
        d  = $random(seed);
        drive_sources(ce, d);
        exp_gpo = next_gpo(exp_gpo, sh_en, sh_sel, ce, d);
        next_cycle();
        bit_compare("gpo", exp_gpo, gpo_o);
    endtask

    //////////////////////////////
    // Baud tick monitor
    //////////////////////////////

    initial begin : tick_monitor
        int   hsk_count;
        int   gps_count;
        logic hsk_prev;
        logic gps_prev;
        hsk_count  = 0;
        gps_count  = 0;
        hsk_prev   = 1'b0;
        gps_prev   = 1'b0;
        ticks_done = 1'b0;
        wait (rst_n_i === 1'b1);
        repeat (TICK_CYCLES) begin
            @(posedge ps_clk);
            #1;
            if (hsk_16x_o && hsk_prev) begin
                other_errs++;
                $display("hsk_16x_o stayed high for two cycles at %0t", $time);
            end
            if (gps_16x_o && gps_prev) begin
                other_errs++;
                $display("gps_16x_o stayed high for two cycles at %0t", $time);
            end
            hsk_count += hsk_16x_o;
            gps_count += gps_16x_o;
            hsk_prev   = hsk_16x_o;
            gps_prev   = gps_16x_o;
        end
        count_compare("hsk_16x count", expect_ticks(TICK_CYCLES, turf_io_pkg::HSK_INC,
                      turf_io_pkg::HSK_ACC_W), hsk_count);
        count_compare("gps_16x count", expect_ticks(TICK_CYCLES, turf_io_pkg::GPS_INC,
                      turf_io_pkg::GPS_ACC_W), gps_count);
        ticks_done = 1'b1;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge ps_clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        turf_id_pkg::reg_data_t  wdata;
        turf_io_pkg::emio_word_t prev_word;
        logic [31:0]             r;
        logic [3:0]              pulse;
        logic [3:0]              mask;
        int                      total;
        rst_n_i          = 1'b0;
        wr_stb_i         = 1'b0;
        rd_stb_i         = 1'b0;
        addr_i           = '0;
        wdata_i          = '0;
        aurora_up_i      = '0;
        bridge_timeout_i = '0;
        drive_sources(4'h0, 4'h0);
        timepulse_i      = 2'b00;
        pps_pulse_i      = 1'b0;
        hsk_complete_i   = 1'b0;
        hsk_irq_i        = 1'b0;
        uart_irq_b_i     = 1'b1;
        photoshutter_i   = 1'b0;
        emio_o_i         = '0;
        emio_t_i         = 16'hffff;
        sh_en            = 1'b0;
        sh_sel           = 3'd0;
        sh_btype         = 8'h00;
        sh_sticky        = 4'h0;
        exp_gpo          = 1'b0;

        repeat (RESET_CYCLES) @(posedge ps_clk);
        #2;
        rst_n_i = 1'b1;
        reg_compare("rdata after reset", '0, rdata_o);
        bit_compare("gpo after reset", 1'b0, gpo_o);
        bit_compare("gpo_en_o after reset", 1'b0, gpo_en_o);
        sel_compare("gpo_select_o after reset", turf_io_pkg::GPO_SYNC, gpo_select_o);
        btype_compare("bridge_type_o after reset", 8'h00, bridge_type_o);

        // Ident and version are read only
        read_check("ident", turf_id_pkg::ADDR_IDENT);
        read_check("dateversion", turf_id_pkg::ADDR_DATEVER);
        write_reg(turf_id_pkg::ADDR_DATEVER, $random(seed));
        write_reg(turf_id_pkg::ADDR_IDENT, $random(seed));
        reg_compare("rdata held over writes",
                    expect_rdata(turf_id_pkg::ADDR_DATEVER, aurora_up_i), rdata_o);
        read_check("ident after write", turf_id_pkg::ADDR_IDENT);
        read_check("dateversion after write", turf_id_pkg::ADDR_DATEVER);

        // Control readback
        repeat (8) begin
            wdata = $random(seed);
            write_reg(turf_id_pkg::ADDR_CTRL, wdata);
            sh_en    = wdata[0];
            sh_sel   = wdata[3:1];
            sh_btype = wdata[15:8];
            bit_compare("gpo_en_o", sh_en, gpo_en_o);
            sel_compare("gpo_select_o", turf_io_pkg::gpo_sel_t'(sh_sel), gpo_select_o);
            btype_compare("bridge_type_o", sh_btype, bridge_type_o);
            read_check("ctrl readback", turf_id_pkg::ADDR_CTRL);
        end

        // Bridge valid and sticky timeouts, set and clear may share an edge
        repeat (24) begin
            r                = $random(seed);
            pulse            = r[3:0] & r[7:4];
            bridge_timeout_i = pulse;
            mask             = 4'h0;
            if (r[8]) begin
                wdata = $random(seed);
                mask  = wdata[19:16];
                write_reg(turf_id_pkg::ADDR_BRIDGE, wdata);
            end else begin
                next_cycle();
            end
            bridge_timeout_i = '0;
            sh_sticky        = (sh_sticky & ~mask) | pulse;
            aurora_up_i      = r[15:12];
            read_check("bridge status", turf_id_pkg::ADDR_BRIDGE);
        end

        // GPO mux over every select and enable
        for (int en = 0; en < 2; en++) begin
            for (int sel = 0; sel < 8; sel++) begin
                drive_sources(4'h0, 4'h0);
                wdata      = $random(seed);
                wdata[3:0] = {sel[2:0], en[0]};
                exp_gpo    = next_gpo(exp_gpo, sh_en, sh_sel, 4'h0, 4'h0);
                write_reg(turf_id_pkg::ADDR_CTRL, wdata);
                sh_en    = en[0];
                sh_sel   = sel[2:0];
                sh_btype = wdata[15:8];
                bit_compare("gpo after ctrl write", exp_gpo, gpo_o);
                repeat (12) gpo_cycle();
            end
        end
        drive_sources(4'h0, 4'h0);

        // EMIO word lags its inputs by two cycles
        prev_word = expect_emio(timepulse_i, pps_pulse_i, hsk_complete_i, hsk_irq_i,
                                uart_irq_b_i);
        repeat (32) begin
            r              = $random(seed);
            timepulse_i    = r[1:0];
            pps_pulse_i    = r[2];
            hsk_complete_i = r[3];
            hsk_irq_i      = r[4];
            uart_irq_b_i   = r[5];
            photoshutter_i = r[6];
            emio_o_i       = r[31:16];
            emio_t_i       = $random(seed);
            #1;
            bit_compare("gps_extint[0]", photoshutter_i, gps_extint_o[0]);
            bit_compare("gps_extint[1]", emio_o_i[9] & ~emio_t_i[9], gps_extint_o[1]);
            next_cycle();
            emio_compare("emio word", prev_word, emio_word_o);
            prev_word = expect_emio(timepulse_i, pps_pulse_i, hsk_complete_i, hsk_irq_i,
                                    uart_irq_b_i);
        end

        wait (ticks_done === 1'b1);
        total = data_errs + bit_errs + ctrl_errs + emio_errs + count_errs + other_errs;
        $display("Errors: data %0d, bit %0d, ctrl %0d, emio %0d, count %0d, other %0d, total %0d",
                 data_errs, bit_errs, ctrl_errs, emio_errs, count_errs, other_errs, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== src/turf_hsk_top.sv ====
`timescale 1ns/100ps
module turf_hsk_top (
    input  logic                              ps_clk,
    input  logic                              rst_n_i,

    // Register strobe port
    input  logic                              wr_stb_i,
    input  logic                              rd_stb_i,
    input  turf_id_pkg::reg_addr_t            addr_i,
    input  turf_id_pkg::reg_data_t            wdata_i,
    output turf_id_pkg::reg_data_t            rdata_o,

    input  logic [turf_id_pkg::NUM_LINKS-1:0] aurora_up_i,
    input  logic [turf_id_pkg::NUM_LINKS-1:0] bridge_timeout_i,
    output logic                              gpo_en_o,
    output turf_io_pkg::gpo_sel_t             gpo_select_o,
    output logic [7:0]                        bridge_type_o,

    // GPO sources
    input  logic                              sync_ce_i,
    input  logic                              sync_d_i,
    input  logic                              run_ce_i,
    input  logic                              run_d_i,
    input  logic                              trig_ce_i,
    input  logic                              trig_d_i,
    input  logic                              pps_ce_i,
    input  logic                              pps_d_i,
    output logic                              gpo_o,

    // EMIO and GPS pins
    input  logic [1:0]                        timepulse_i,
    input  logic                              pps_pulse_i,
    input  logic                              hsk_complete_i,
    input  logic                              hsk_irq_i,
    input  logic                              uart_irq_b_i,
    input  logic                              photoshutter_i,
    input  logic [15:0]                       emio_o_i,
    input  logic [15:0]                       emio_t_i,
    output turf_io_pkg::emio_word_t           emio_word_o,
    output logic [1:0]                        gps_extint_o,

    // 16x baud ticks
    output logic                              hsk_16x_o,
    output logic                              gps_16x_o
);

    turf_id_regs u_regs (
        .ps_clk           (ps_clk),
        .rst_n_i          (rst_n_i),
        .wr_stb_i         (wr_stb_i),
        .rd_stb_i         (rd_stb_i),
        .addr_i           (addr_i),
        .wdata_i          (wdata_i),
        .rdata_o          (rdata_o),
        .aurora_up_i      (aurora_up_i),
        .bridge_timeout_i (bridge_timeout_i),
        .gpo_en_o         (gpo_en_o),
        .gpo_select_o     (gpo_select_o),
        .bridge_type_o    (bridge_type_o)
    );

    // TOUT driver
    turf_gpo_mux u_gpo_mux (
        .ps_clk       (ps_clk),
        .rst_n_i      (rst_n_i),
        .gpo_en_i     (gpo_en_o),
        .gpo_select_i (gpo_select_o),
        .sync_ce_i    (sync_ce_i),
        .sync_d_i     (sync_d_i),
        .run_ce_i     (run_ce_i),
        .run_d_i      (run_d_i),
        .trig_ce_i    (trig_ce_i),
        .trig_d_i     (trig_d_i),
        .pps_ce_i     (pps_ce_i),
        .pps_d_i      (pps_d_i),
        .gpo_o        (gpo_o)
    );

    turf_emio_gpio u_emio (
        .ps_clk         (ps_clk),
        .rst_n_i        (rst_n_i),
        .timepulse_i    (timepulse_i),
        .pps_pulse_i    (pps_pulse_i),
        .hsk_complete_i (hsk_complete_i),
        .hsk_irq_i      (hsk_irq_i),
        .uart_irq_b_i   (uart_irq_b_i),
        .photoshutter_i (photoshutter_i),
        .emio_o_i       (emio_o_i),
        .emio_t_i       (emio_t_i),
        .emio_word_o    (emio_word_o),
        .gps_extint_o   (gps_extint_o)
    );

    //////////////////////////////
    // Baud generators
    //////////////////////////////

    turf_baud_tick #(
        .ACC_W (turf_io_pkg::HSK_ACC_W),
        .INC   (turf_io_pkg::HSK_INC)
    ) u_hsk_baud (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (hsk_16x_o)
    );

    turf_baud_tick #(
        .ACC_W (turf_io_pkg::GPS_ACC_W),
        .INC   (turf_io_pkg::GPS_INC)
    ) u_gps_baud (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (gps_16x_o)
    );

endmodule

// ==== src/turf_id_regs.sv ====
`timescale 1ns/100ps
module turf_id_regs (
    input  logic                                  ps_clk,
    input  logic                                  rst_n_i,

    input  logic                                  wr_stb_i,
    input  logic                                  rd_stb_i,
    input  turf_id_pkg::reg_addr_t                addr_i,
    input  turf_id_pkg::reg_data_t                wdata_i,
    output turf_id_pkg::reg_data_t                rdata_o,

    input  logic [turf_id_pkg::NUM_LINKS-1:0]     aurora_up_i,
    input  logic [turf_id_pkg::NUM_LINKS-1:0]     bridge_timeout_i,

    output logic                                  gpo_en_o,
    output turf_io_pkg::gpo_sel_t                 gpo_select_o,
    output logic [7:0]                            bridge_type_o
);

    //////////////////////////////
    // Bridge status
    //////////////////////////////

    turf_id_pkg::bridge_valid_t              bridge_valid;
    logic [turf_id_pkg::NUM_LINKS-1:0]       timeout_q;
    logic [turf_id_pkg::NUM_LINKS-1:0]       timeout_clr;

    // Per link: two unimplemented types, Aurora, and the always-valid none type
    generate
        for (genvar n = 0; n < turf_id_pkg::NUM_LINKS; n++) begin : g_valid
            assign bridge_valid[4*n +: 4] = {2'b00, aurora_up_i[n], 1'b1};
        end
    endgenerate

    // Write-one-to-clear on the bridge register
    assign timeout_clr = (wr_stb_i && addr_i == turf_id_pkg::ADDR_BRIDGE)
                         ? wdata_i[19:16] : '0;

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            timeout_q <= '0;
        end else begin
            // A new timeout beats a clear on the same edge
            timeout_q <= (timeout_q & ~timeout_clr) | bridge_timeout_i;
        end
    end

    //////////////////////////////
    // Control register
    //////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            gpo_en_o      <= 1'b0;
            gpo_select_o  <= turf_io_pkg::GPO_SYNC;
            bridge_type_o <= 8'h00;
        end else if (wr_stb_i && addr_i == turf_id_pkg::ADDR_CTRL) begin
            gpo_en_o      <= wdata_i[0];
            gpo_select_o  <= turf_io_pkg::gpo_sel_t'(wdata_i[3:1]);
            bridge_type_o <= wdata_i[15:8];
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////

    turf_id_pkg::reg_data_t rd_mux;

    always_comb begin
        rd_mux = '0;
        case (addr_i)
            turf_id_pkg::ADDR_IDENT:   rd_mux = turf_id_pkg::IDENT_WORD;
            turf_id_pkg::ADDR_DATEVER: rd_mux = turf_id_pkg::DATEVERSION;
            turf_id_pkg::ADDR_CTRL: begin
                rd_mux[0]    = gpo_en_o;
                rd_mux[3:1]  = gpo_select_o;
                rd_mux[15:8] = bridge_type_o;
            end
            turf_id_pkg::ADDR_BRIDGE: begin
                rd_mux[15:0]  = bridge_valid;
                rd_mux[19:16] = timeout_q;
            end
        endcase
    end

    // Held until the next read strobe
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else if (rd_stb_i) begin
            rdata_o <= rd_mux;
        end
    end

    // The bus side issues one access per cycle
    a_no_rw_overlap: assert property (
        @(posedge ps_clk) disable iff (!rst_n_i)
        !(wr_stb_i && rd_stb_i)
    );

endmodule

// ==== src/turf_emio_gpio.sv ====
`timescale 1ns/100ps
module turf_emio_gpio (
    input  logic                   ps_clk,
    input  logic                   rst_n_i,

    input  logic [1:0]             timepulse_i,
    input  logic                   pps_pulse_i,
    input  logic                   hsk_complete_i,
    input  logic                   hsk_irq_i,
    input  logic                   uart_irq_b_i,

    input  logic                   photoshutter_i,
    input  logic [15:0]            emio_o_i,
    input  logic [15:0]            emio_t_i,

    output turf_io_pkg::emio_word_t emio_word_o,
    output logic [1:0]             gps_extint_o
);

    // Levels that cross into ps_clk
    localparam int SYNC_W = 5;

    logic [SYNC_W-1:0] async_lvl;
    logic [SYNC_W-1:0] sync_q1;
    logic [SYNC_W-1:0] sync_q2;

    // Timepulse 0 goes to the time subsystem, only timepulse 1 lands here
    assign async_lvl = {timepulse_i[1], pps_pulse_i, hsk_complete_i,
                        hsk_irq_i, uart_irq_b_i};

    //////////////////////////////
    // Two-stage synchronizer
    //////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= async_lvl;
            sync_q2 <= sync_q1;
        end
    end

    // Pack into the EMIO layout, unused bits stay zero
    always_comb begin
        emio_word_o = '0;
        emio_word_o[turf_io_pkg::EMIO_TP1_BIT]      = sync_q2[4];
        emio_word_o[turf_io_pkg::EMIO_PPS_BIT]      = sync_q2[3];
        emio_word_o[turf_io_pkg::EMIO_HSK_DONE_BIT] = sync_q2[2];
        emio_word_o[turf_io_pkg::EMIO_HSK_IRQ_BIT]  = sync_q2[1];
        emio_word_o[turf_io_pkg::EMIO_UART_IRQ_BIT] = sync_q2[0];
    end

    //////////////////////////////
    // GPS external interrupts
    //////////////////////////////

    assign gps_extint_o[0] = photoshutter_i;
    // Only driven high while the EMIO pin is an output
    assign gps_extint_o[1] = emio_o_i[turf_io_pkg::EMIO_EXTINT_BIT]
                             & ~emio_t_i[turf_io_pkg::EMIO_EXTINT_BIT];

endmodule

// ==== src/turf_gpo_mux.sv ====
`timescale 1ns/100ps
module turf_gpo_mux (
    input  logic                 ps_clk,
    input  logic                 rst_n_i,

    input  logic                 gpo_en_i,
    input  turf_io_pkg::gpo_sel_t gpo_select_i,

    input  logic                 sync_ce_i,
    input  logic                 sync_d_i,
    input  logic                 run_ce_i,
    input  logic                 run_d_i,
    input  logic                 trig_ce_i,
    input  logic                 trig_d_i,
    input  logic                 pps_ce_i,
    input  logic                 pps_d_i,

    output logic                 gpo_o
);

    //////////////////////////////
    // Source decode
    //////////////////////////////

    logic sel_valid;
    logic sel_ce;
    logic sel_d;

    always_comb begin
        sel_valid = 1'b1;
        sel_ce    = 1'b0;
        sel_d     = 1'b0;
        case (gpo_select_i)
            turf_io_pkg::GPO_SYNC: begin
                sel_ce = sync_ce_i;
                sel_d  = sync_d_i;
            end
            turf_io_pkg::GPO_RUN: begin
                sel_ce = run_ce_i;
                sel_d  = run_d_i;
            end
            turf_io_pkg::GPO_TRIG: begin
                sel_ce = trig_ce_i;
                sel_d  = trig_d_i;
            end
            turf_io_pkg::GPO_PPS: begin
                sel_ce = pps_ce_i;
                sel_d  = pps_d_i;
            end
            default: begin
                // Unassigned code
                sel_valid = 1'b0;
            end
        endcase
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            gpo_o <= 1'b0;
        end else if (!gpo_en_i || !sel_valid) begin
            gpo_o <= 1'b0;
        end else if (sel_ce) begin
            gpo_o <= sel_d;
        end
    end

endmodule

// ==== src/turf_baud_tick.sv ====
`timescale 1ns/100ps
module turf_baud_tick #(
    parameter int ACC_W = 10,
    parameter int INC   = 82
) (
    input  logic ps_clk,
    input  logic rst_n_i,
    output logic tick_o
);

    // Increment extended to the accumulator width
    localparam logic [ACC_W:0] INC_EXT = (ACC_W + 1)'(INC);

    // Top bit holds the carry out of the last addition
    logic [ACC_W:0] acc;

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            acc <= '0;
        end else begin
            // Carry is dropped before each add so it lasts one cycle
            acc <= {1'b0, acc[ACC_W-1:0]} + INC_EXT;
        end
    end

    assign tick_o = acc[ACC_W];

    // Back-to-back carries are impossible at up to half the range
    generate
        if (INC <= (1 << (ACC_W - 1))) begin : g_tick_chk
            a_single_cycle_tick: assert property (
                @(posedge ps_clk) disable iff (!rst_n_i)
                tick_o |=> !tick_o
            );
        end
    endgenerate

endmodule

// ==== src/turf_io_pkg.sv ====
package turf_io_pkg;

    //////////////////////////////
    // General-purpose output
    //////////////////////////////

    // Source selection for TOUT
    // Codes 4 to 7 are not assigned and force the output low
    typedef enum logic [2:0] {
        GPO_SYNC = 3'd0,
        GPO_RUN  = 3'd1,
        GPO_TRIG = 3'd2,
        GPO_PPS  = 3'd3
    } gpo_sel_t;

    //////////////////////////////
    // EMIO input word
    //////////////////////////////

    typedef logic [11:0] emio_word_t;

    // Bit positions inside emio_word_t
    localparam int EMIO_TP1_BIT      = 11;
    localparam int EMIO_PPS_BIT      = 10;
    localparam int EMIO_HSK_DONE_BIT = 2;
    localparam int EMIO_HSK_IRQ_BIT  = 1;
    // Active low, passed through as is
    localparam int EMIO_UART_IRQ_BIT = 0;

    // EMIO output that drives the second GPS external interrupt
    localparam int EMIO_EXTINT_BIT = 9;

    //////////////////////////////
    // 16x baud generators
    //////////////////////////////

    // Housekeeping link at 8 MHz from 100 MHz
    // 82/1024 is within 0.1% of 1/12.5
    localparam int HSK_ACC_W = 10;
    localparam int HSK_INC   = 82;

    // GPS link at 38400 baud, 16x oversampled
    localparam int GPS_ACC_W = 12;
    localparam int GPS_INC   = 25;

endpackage

// ==== src/turf_id_pkg.sv ====
package turf_id_pkg;

    //////////////////////////////
    // Identity and version
    //////////////////////////////

    // Four ASCII characters, first character in the top byte
    localparam logic [31:0] IDENT_WORD = "TURF";

    localparam logic [3:0] VER_MAJOR = 4'd0;
    localparam logic [3:0] VER_MINOR = 4'd8;
    localparam logic [7:0] VER_REV   = 8'd12;

    // Only the low 15 bits of the date code reach DATEVERSION
    localparam logic [15:0] FW_DATE = 16'h5a1c;
    localparam logic        REV_B   = 1'b1;

    localparam logic [31:0] DATEVERSION = {REV_B, FW_DATE[14:0],
                                           VER_MAJOR, VER_MINOR, VER_REV};

    //////////////////////////////
    // Register map
    //////////////////////////////

    typedef logic [1:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;

    localparam reg_addr_t ADDR_IDENT   = 2'd0;
    localparam reg_addr_t ADDR_DATEVER = 2'd1;
    localparam reg_addr_t ADDR_CTRL    = 2'd2;
    localparam reg_addr_t ADDR_BRIDGE  = 2'd3;

    //////////////////////////////
    // Crate bridge
    //////////////////////////////

    // One Aurora link per TURFIO
    localparam int NUM_LINKS = 4;

    // Four valid flags per link
    typedef logic [15:0] bridge_valid_t;

endpackage
